// File: hdl/bp_pkg.sv
package bp_pkg;

    // address and instruction widths
    typedef logic [63:0] addr_t;     // virtual address
    typedef logic [31:0] instr_t;    // one aarch64 instruction word
    typedef logic [7:0]  line_off_t; // byte offset inside a cache line, lines up to 256 bytes

    // branch kind codes
    typedef logic [2:0] br_kind_t;

    localparam br_kind_t BR_NONE  = 3'd0; // not a branch we know about
    localparam br_kind_t BR_B     = 3'd1; // unconditional, imm26
    localparam br_kind_t BR_BL    = 3'd2; // call, pushes return address
    localparam br_kind_t BR_BCOND = 3'd3; // conditional, imm19
    localparam br_kind_t BR_RET   = 3'd4; // return, target from the stack

    // result of predecoding one slot
    typedef struct packed {
        logic     valid;  // slot lies inside the fetched line
        br_kind_t kind;
        logic     taken;  // static prediction, RET is resolved later against the stack
        addr_t    target; // pc relative target, zero for RET and non-branches
    } slot_info_t;

    // request to the L1 instruction cache
    typedef struct packed {
        addr_t     line_addr; // line aligned
        line_off_t offset;    // byte offset of the first instruction wanted
    } l1i_req_t;

    // fetch controller states
    typedef enum logic [0:0] {
        IDLE  = 1'b0, // nothing requested yet
        AWAIT = 1'b1  // one request outstanding
    } fetch_state_e;

endpackage

// File: hdl/fetch_ctrl.sv
`timescale 1ns/100ps

module fetch_ctrl #(
    parameter int CACHE_LINE_BYTES = 64,
    parameter int SLOT_COUNT       = 4
) (
    input  logic                                  clk_in,
    input  logic                                  arst_n,
    input  logic                                  redirect_valid,
    input  bp_pkg::addr_t                         redirect_pc,
    input  logic                                  l1i_resp_valid,
    input  logic [CACHE_LINE_BYTES-1:0][7:0]      l1i_resp_line,
    input  logic                                  next_valid,
    input  bp_pkg::addr_t                         next_pc,
    output logic                                  l1i_req_valid,
    output bp_pkg::l1i_req_t                      l1i_req,
    output logic                                  line_valid,
    output bp_pkg::addr_t                         fetch_pc,
    output bp_pkg::instr_t [SLOT_COUNT-1:0]       slot_words,
    output logic [SLOT_COUNT-1:0]                 slot_in_line
);
    import bp_pkg::*;

    localparam int OFF_W  = $clog2(CACHE_LINE_BYTES);
    localparam int WORDS  = CACHE_LINE_BYTES / 4;
    localparam int WIDX_W = OFF_W - 2; // word index within a line

    fetch_state_e state_q, state_d;
    addr_t        awaited_pc;          // pc the outstanding request belongs to
    addr_t        pc_d;
    logic         req_d;

    // same bits as the byte array, byte 0 ends up in the low bits of word 0
    instr_t [WORDS-1:0] line_words;
    logic   [WIDX_W:0]  idx;           // one extra bit to see running off the line

    assign line_words = l1i_resp_line;

    // a redirect squashes whatever response shows up with it
    assign line_valid = l1i_resp_valid && (state_q == AWAIT) && !redirect_valid;
    assign fetch_pc   = awaited_pc;

    // request fields come straight from the awaited pc register
    assign l1i_req.line_addr = awaited_pc & ~addr_t'(CACHE_LINE_BYTES - 1);
    assign l1i_req.offset    = line_off_t'(awaited_pc[OFF_W-1:0]);

    always_comb begin
        state_d = state_q;
        pc_d    = awaited_pc;
        req_d   = 1'b0;
        if (redirect_valid) begin   // redirect beats the predicted pc
            state_d = AWAIT;
            pc_d    = redirect_pc;
            req_d   = 1'b1;
        end else if (line_valid) begin
            if (next_valid) begin   // chain straight on to the predicted pc
                state_d = AWAIT;
                pc_d    = next_pc;
                req_d   = 1'b1;
            end else begin
                state_d = IDLE;
            end
        end
    end

    // slot i takes the word i positions after the awaited one
    always_comb begin
        idx = '0;
        for (int i = 0; i < SLOT_COUNT; i++) begin
            idx             = {1'b0, awaited_pc[OFF_W-1:2]} + (WIDX_W + 1)'(i);
            slot_in_line[i] = (idx < (WIDX_W + 1)'(WORDS));
            slot_words[i]   = slot_in_line[i] ? line_words[idx[WIDX_W-1:0]] : '0;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state_q       <= IDLE;
            l1i_req_valid <= 1'b0;
        end else begin
            state_q       <= state_d;
            l1i_req_valid <= req_d; // one cycle strobe
        end
    end

    // awaited address only moves together with a new request
    always_ff @(posedge clk_in) begin
        awaited_pc <= pc_d;
    end

endmodule

// File: hdl/predecode_slot.sv
`timescale 1ns/100ps

module predecode_slot (
    input  bp_pkg::instr_t     slot_word,
    input  bp_pkg::addr_t      slot_pc,
    input  logic               in_line,
    output bp_pkg::slot_info_t info
);
    import bp_pkg::*;

    logic     is_b;
    logic     is_bl;
    logic     is_bcond;
    logic     is_ret;
    addr_t    off26;   // sign extended imm26 times four
    addr_t    off19;   // sign extended imm19 times four
    br_kind_t kind;

    // opcode matches
    assign is_b     = (slot_word[31:26] == 6'b000101);
    assign is_bl    = (slot_word[31:26] == 6'b100101);
    assign is_bcond = (slot_word[31:24] == 8'b01010100) && !slot_word[4]; // bit 4 set is BC.cond
    // RET Xn, any Rn though the compiler nearly always uses x30
    assign is_ret   = (slot_word[31:10] == 22'b1101011001011111000000) &&
                      (slot_word[4:0] == 5'b00000);

    assign off26 = {{36{slot_word[25]}}, slot_word[25:0], 2'b00};
    assign off19 = {{43{slot_word[23]}}, slot_word[23:5], 2'b00};

    always_comb begin
        if (is_b) begin
            kind = BR_B;
        end else if (is_bl) begin
            kind = BR_BL;
        end else if (is_bcond) begin
            kind = BR_BCOND;
        end else if (is_ret) begin
            kind = BR_RET;
        end else begin
            kind = BR_NONE;
        end
    end

    always_comb begin
        info.valid  = in_line;
        info.kind   = in_line ? kind : BR_NONE; // words past the line end mean nothing
        info.taken  = 1'b0;
        info.target = '0;
        if (in_line) begin
            case (kind)
                BR_B, BR_BL: begin
                    info.taken  = 1'b1;             // always taken
                    info.target = slot_pc + off26;
                end
                BR_BCOND: begin
                    info.taken  = slot_word[23];    // backward taken, forward not
                    info.target = slot_pc + off19;
                end
                default: begin
                    // RET target comes from the stack in bundle_select
                    info.taken  = 1'b0;
                    info.target = '0;
                end
            endcase
        end
    end

endmodule

// File: hdl/return_stack.sv
`timescale 1ns/100ps

module return_stack #(
    parameter int RAS_DEPTH = 8
) (
    input  logic          clk_in,
    input  logic          arst_n,
    input  logic          push,
    input  logic          pop,
    input  bp_pkg::addr_t push_addr,
    output bp_pkg::addr_t top_addr,
    output logic          empty
);
    import bp_pkg::*;

    localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RAS_DEPTH + 1);

    addr_t            entries [RAS_DEPTH];
    logic [PTR_W-1:0] tos;      // index of the top entry
    logic [PTR_W-1:0] tos_inc;
    logic [PTR_W-1:0] tos_dec;
    logic [CNT_W-1:0] count;    // saturates at RAS_DEPTH, oldest entry gets overwritten

    // explicit wrap so depth need not be a power of two
    assign tos_inc = (tos == PTR_W'(RAS_DEPTH - 1)) ? '0 : tos + 1'b1;
    assign tos_dec = (tos == '0) ? PTR_W'(RAS_DEPTH - 1) : tos - 1'b1;

    assign top_addr = entries[tos];
    assign empty    = (count == '0);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            tos   <= '0;
            count <= '0;
        end else if (push && !pop) begin
            tos   <= tos_inc;
            count <= (count == CNT_W'(RAS_DEPTH)) ? count : count + 1'b1;
        end else if (pop && !push) begin
            tos   <= tos_dec;
            count <= empty ? count : count - 1'b1; // pop on empty is never issued anyway
        end
    end

    // push with pop at once replaces the top in place
    always_ff @(posedge clk_in) begin
        if (push && !pop) begin
            entries[tos_inc] <= push_addr;
        end else if (push && pop) begin
            entries[tos] <= push_addr;
        end
    end

endmodule

// File: hdl/bundle_select.sv
`timescale 1ns/100ps

module bundle_select #(
    parameter int SLOT_COUNT = 4
) (
    input  logic                                  clk_in,
    input  logic                                  arst_n,
    input  logic                                  line_valid,
    input  bp_pkg::addr_t                         fetch_pc,
    input  bp_pkg::slot_info_t [SLOT_COUNT-1:0]   slot_infos,
    input  bp_pkg::addr_t                         ras_top,
    input  logic                                  ras_empty,
    output logic                                  ras_push,
    output logic                                  ras_pop,
    output bp_pkg::addr_t                         ras_push_addr,
    output logic                                  bundle_valid,
    output bp_pkg::addr_t                         bundle_pc,
    output logic [$clog2(SLOT_COUNT+1)-1:0]       bundle_count,
    output bp_pkg::slot_info_t [SLOT_COUNT-1:0]   bundle_slots,
    output bp_pkg::addr_t                         pred_pc,
    output logic                                  next_valid,
    output bp_pkg::addr_t                         next_pc
);
    import bp_pkg::*;

    localparam int CNT_W = $clog2(SLOT_COUNT + 1);

    logic                         found;       // a taken slot ends the bundle
    logic [CNT_W-1:0]             count_c;
    addr_t                        tgt_c;
    logic                         push_c;
    logic                         pop_c;
    addr_t                        push_addr_c;
    slot_info_t [SLOT_COUNT-1:0]  slots_c;

    // scan slots in program order, stop at the first taken one
    always_comb begin
        found       = 1'b0;
        count_c     = '0;
        tgt_c       = '0;
        push_c      = 1'b0;
        pop_c       = 1'b0;
        push_addr_c = '0;
        slots_c     = '0;
        for (int i = 0; i < SLOT_COUNT; i++) begin
            if (!found && slot_infos[i].valid) begin
                count_c    = CNT_W'(i + 1);
                slots_c[i] = slot_infos[i];
                if (slot_infos[i].kind == BR_RET && !ras_empty) begin
                    found             = 1'b1;
                    tgt_c             = ras_top;
                    pop_c             = 1'b1;
                    slots_c[i].taken  = 1'b1;     // report the stack prediction
                    slots_c[i].target = ras_top;
                end else if (slot_infos[i].taken) begin
                    found = 1'b1;
                    tgt_c = slot_infos[i].target;
                    if (slot_infos[i].kind == BR_BL) begin
                        push_c      = 1'b1;
                        push_addr_c = fetch_pc + addr_t'(4 * (i + 1)); // return lands after the BL
                    end
                end
            end
        end
    end

    // fall through goes to the word after the last slot, possibly the next line
    assign next_pc    = found ? tgt_c : fetch_pc + (addr_t'(count_c) << 2);
    assign next_valid = line_valid; // fetch_ctrl registers the request itself

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            bundle_valid <= 1'b0;
            ras_push     <= 1'b0;
            ras_pop      <= 1'b0;
        end else begin
            bundle_valid <= line_valid;
            ras_push     <= line_valid && push_c;
            ras_pop      <= line_valid && pop_c;
        end
    end

    // payload, only looked at while its strobe is high
    always_ff @(posedge clk_in) begin
        bundle_pc     <= fetch_pc;
        bundle_count  <= count_c;
        bundle_slots  <= slots_c;
        pred_pc       <= next_pc;
        ras_push_addr <= push_addr_c;
    end

endmodule

// File: hdl/branch_pred_top.sv
`timescale 1ns/100ps

module branch_pred_top #(
    parameter int CACHE_LINE_BYTES = 64,
    parameter int SLOT_COUNT       = 4,
    parameter int RAS_DEPTH        = 8
) (
    input  logic                                  clk_in,
    input  logic                                  arst_n,
    input  logic                                  redirect_valid,
    input  bp_pkg::addr_t                         redirect_pc,
    output logic                                  l1i_req_valid,
    output bp_pkg::l1i_req_t                      l1i_req,
    input  logic                                  l1i_resp_valid,
    input  logic [CACHE_LINE_BYTES-1:0][7:0]      l1i_resp_line,
    output logic                                  bundle_valid,
    output bp_pkg::addr_t                         bundle_pc,
    output logic [$clog2(SLOT_COUNT+1)-1:0]       bundle_count,
    output bp_pkg::slot_info_t [SLOT_COUNT-1:0]   bundle_slots,
    output bp_pkg::addr_t                         pred_pc
);
    import bp_pkg::*;

    logic                        line_valid;
    addr_t                       fetch_pc;
    instr_t     [SLOT_COUNT-1:0] slot_words;
    logic       [SLOT_COUNT-1:0] slot_in_line;
    slot_info_t [SLOT_COUNT-1:0] slot_infos;
    logic                        next_valid;  // combinational, same cycle as line_valid
    addr_t                       next_pc;
    logic                        ras_push;
    logic                        ras_pop;
    addr_t                       ras_push_addr;
    addr_t                       ras_top;
    logic                        ras_empty;

    fetch_ctrl #(
        .CACHE_LINE_BYTES(CACHE_LINE_BYTES),
        .SLOT_COUNT      (SLOT_COUNT)
    ) i_fetch_ctrl (
        .clk_in        (clk_in),
        .arst_n        (arst_n),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .l1i_resp_valid(l1i_resp_valid),
        .l1i_resp_line (l1i_resp_line),
        .next_valid    (next_valid),
        .next_pc       (next_pc),
        .l1i_req_valid (l1i_req_valid),
        .l1i_req       (l1i_req),
        .line_valid    (line_valid),
        .fetch_pc      (fetch_pc),
        .slot_words    (slot_words),
        .slot_in_line  (slot_in_line)
    );

    // one predecoder per slot, slot g sits 4*g bytes after fetch_pc
    for (genvar g = 0; g < SLOT_COUNT; g++) begin : g_slot
        predecode_slot i_predecode_slot (
            .slot_word(slot_words[g]),
            .slot_pc  (fetch_pc + addr_t'(4 * g)),
            .in_line  (slot_in_line[g]),
            .info     (slot_infos[g])
        );
    end

    bundle_select #(
        .SLOT_COUNT(SLOT_COUNT)
    ) i_bundle_select (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .line_valid   (line_valid),
        .fetch_pc     (fetch_pc),
        .slot_infos   (slot_infos),
        .ras_top      (ras_top),
        .ras_empty    (ras_empty),
        .ras_push     (ras_push),
        .ras_pop      (ras_pop),
        .ras_push_addr(ras_push_addr),
        .bundle_valid (bundle_valid),
        .bundle_pc    (bundle_pc),
        .bundle_count (bundle_count),
        .bundle_slots (bundle_slots),
        .pred_pc      (pred_pc),
        .next_valid   (next_valid),
        .next_pc      (next_pc)
    );

    return_stack #(
        .RAS_DEPTH(RAS_DEPTH)
    ) i_return_stack (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .push     (ras_push),
        .pop      (ras_pop),
        .push_addr(ras_push_addr),
        .top_addr (ras_top),
        .empty    (ras_empty)
    );

endmodule

// File: testbench/branch_pred_properties.sv
`timescale 1ns/100ps

module branch_pred_properties #(
    parameter int CACHE_LINE_BYTES = 64,
    parameter int SLOT_COUNT       = 4
) (
    input logic                              clk_in,
    input logic                              arst_n,
    input logic                              l1i_req_valid,
    input bp_pkg::l1i_req_t                  l1i_req,
    input logic                              l1i_resp_valid,
    input logic                              bundle_valid,
    input logic [$clog2(SLOT_COUNT+1)-1:0]   bundle_count,
    input bp_pkg::addr_t                     pred_pc
);
    import bp_pkg::*;

    localparam int OFF_W = $clog2(CACHE_LINE_BYTES);

    // bundle and request for its predicted pc leave together
    a_req_with_bundle: assert property (@(posedge clk_in) disable iff (!arst_n)
        bundle_valid |-> l1i_req_valid
            && l1i_req.line_addr == (pred_pc & ~addr_t'(CACHE_LINE_BYTES - 1))
            && l1i_req.offset == line_off_t'(pred_pc[OFF_W-1:0]))
        else $error("bundle without a request for pred_pc");

    a_count_range: assert property (@(posedge clk_in) disable iff (!arst_n)
        bundle_valid |-> bundle_count >= 1 && bundle_count <= SLOT_COUNT)
        else $error("bundle_count out of range");

    a_resp_before_bundle: assert property (@(posedge clk_in) disable iff (!arst_n)
        bundle_valid |-> $past(l1i_resp_valid))
        else $error("bundle not preceded by a response");

    a_quiet_in_reset: assert property (@(posedge clk_in)
        !arst_n |-> !l1i_req_valid && !bundle_valid)
        else $error("strobe active during reset");

endmodule

bind branch_pred_top branch_pred_properties #(
    .CACHE_LINE_BYTES(CACHE_LINE_BYTES),
    .SLOT_COUNT      (SLOT_COUNT)
) i_branch_pred_properties (
    .clk_in        (clk_in),
    .arst_n        (arst_n),
    .l1i_req_valid (l1i_req_valid),
    .l1i_req       (l1i_req),
    .l1i_resp_valid(l1i_resp_valid),
    .bundle_valid  (bundle_valid),
    .bundle_count  (bundle_count),
    .pred_pc       (pred_pc)
);

// File: testbench/tb_branch_pred.sv
`timescale 1ns/100ps

module tb_branch_pred;
    import bp_pkg::*;

    localparam int CACHE_LINE_BYTES = 64;
    localparam int SLOT_COUNT       = 4;
    localparam int RAS_DEPTH        = 8;
    localparam int WORDS            = CACHE_LINE_BYTES / 4;
    localparam int OFF_W            = $clog2(CACHE_LINE_BYTES);
    localparam int CNT_W            = $clog2(SLOT_COUNT + 1);
    localparam instr_t NOP          = 32'hd503201f;
    localparam instr_t RET          = 32'hd65f03c0; // ret x30

    typedef logic [CNT_W-1:0] count_t;

    logic                                clk_in = 1'b0;
    logic                                arst_n = 1'b0;
    logic                                redirect_valid = 1'b0;
    addr_t                               redirect_pc = '0;
    logic                                l1i_req_valid;
    l1i_req_t                            l1i_req;
    logic                                l1i_resp_valid = 1'b0;
    logic [CACHE_LINE_BYTES-1:0][7:0]    l1i_resp_line = '0;
    logic                                bundle_valid;
    addr_t                               bundle_pc;
    count_t                              bundle_count;
    slot_info_t [SLOT_COUNT-1:0]         bundle_slots;
    addr_t                               pred_pc;

    instr_t mem [addr_t];     // sparse program memory with NOP elsewhere
    addr_t  ras_q [$];        // model return stack with the newest at the back
    addr_t  exp_pc;           // pc the next bundle must start at
    int     bundles_seen;
    string  cur_name = "reset"; // case whose bundles are being checked
    integer seed = 32'h2d78a1ba;

    // cache model state
    logic   hold = 1'b0;      // drop new requests while the next case is set up
    logic   pend_live = 1'b0;
    addr_t  pend_addr;
    int     pend_delay;

    // stimulus table
    string  case_name [$];
    addr_t  case_pc [$];
    instr_t case_w0 [$];
    instr_t case_w1 [$];
    instr_t case_w2 [$];
    instr_t case_w3 [$];
    addr_t  case_aux_pc [$];
    instr_t case_aux_w [$];
    int     case_nb [$];

    branch_pred_top #(
        .CACHE_LINE_BYTES(CACHE_LINE_BYTES),
        .SLOT_COUNT      (SLOT_COUNT),
        .RAS_DEPTH       (RAS_DEPTH)
    ) i_branch_pred_top (
        .clk_in        (clk_in),
        .arst_n        (arst_n),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .l1i_req_valid (l1i_req_valid),
        .l1i_req       (l1i_req),
        .l1i_resp_valid(l1i_resp_valid),
        .l1i_resp_line (l1i_resp_line),
        .bundle_valid  (bundle_valid),
        .bundle_pc     (bundle_pc),
        .bundle_count  (bundle_count),
        .bundle_slots  (bundle_slots),
        .pred_pc       (pred_pc)
    );

    always #2 clk_in = ~clk_in; // 4 ns period

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act)
            report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic compare_count(input string name, input count_t exp, input count_t act);
        if (exp !== act)
            report_failure($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic compare_slot(input string name, input slot_info_t exp, input slot_info_t act);
        if (exp !== act)
            report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    // aarch64 encoders taking byte offsets
    function automatic instr_t enc_b(input int off);
        logic [31:0] o;
        o = off;
        return {6'b000101, o[27:2]};
    endfunction

    function automatic instr_t enc_bl(input int off);
        logic [31:0] o;
        o = off;
        return {6'b100101, o[27:2]};
    endfunction

    function automatic instr_t enc_bcond(input int off);
        logic [31:0] o;
        o = off;
        return {8'h54, o[20:2], 5'b00000}; // b.eq
    endfunction

    function automatic instr_t read_word(input addr_t a);
        return mem.exists(a) ? mem[a] : NOP;
    endfunction

    // expected bundle straight from the branch rules
    task automatic predict(input addr_t pc, output count_t cnt,
                           output slot_info_t [SLOT_COUNT-1:0] slots, output addr_t pred);
        instr_t w;
        addr_t  spc;
        logic   done;
        int     base;
        done  = 1'b0;
        cnt   = '0;
        slots = '0;
        pred  = '0;
        base  = int'(pc[OFF_W-1:2]);
        for (int i = 0; i < SLOT_COUNT; i++) begin
            if (!done && base + i < WORDS) begin
                spc            = pc + 4 * i;
                w              = read_word(spc);
                cnt            = count_t'(i + 1);
                slots[i].valid = 1'b1;
                if (w[31:26] == 6'b000101 || w[31:26] == 6'b100101) begin
                    slots[i].kind   = (w[31]) ? BR_BL : BR_B;
                    slots[i].taken  = 1'b1;
                    slots[i].target = spc + {{36{w[25]}}, w[25:0], 2'b00};
                    done = 1'b1;
                    if (w[31]) begin
                        ras_q.push_back(spc + 4);
                        if (ras_q.size() > RAS_DEPTH) void'(ras_q.pop_front()); // oldest lost
                    end
                end else if (w[31:24] == 8'h54 && !w[4]) begin
                    slots[i].kind   = BR_BCOND;
                    slots[i].taken  = w[23];          // backward only
                    slots[i].target = spc + {{43{w[23]}}, w[23:5], 2'b00};
                    done = w[23];
                end else if (w == RET) begin
                    slots[i].kind = BR_RET;
                    if (ras_q.size() > 0) begin
                        slots[i].taken  = 1'b1;
                        slots[i].target = ras_q.pop_back();
                        done = 1'b1;
                    end
                end
                if (done) pred = slots[i].target;
            end
        end
        if (!done) pred = pc + 4 * cnt;
    endtask

    // cache model with one request at a time and a random latency
    always @(posedge clk_in) begin
        #1;
        l1i_resp_valid = 1'b0;
        if (l1i_req_valid) begin
            pend_addr  = l1i_req.line_addr;
            pend_live  = !hold;
            pend_delay = 1 + ($unsigned($random(seed)) % 5);
        end else if (pend_live) begin
            pend_delay--;
            if (pend_delay == 0) begin
                for (int j = 0; j < WORDS; j++)
                    l1i_resp_line[4*j +: 4] = read_word(pend_addr + 4 * j);
                l1i_resp_valid = 1'b1;
                pend_live      = 1'b0;
            end
        end
    end

    // every bundle is checked against the model
    always @(negedge clk_in) begin
        count_t                      cnt;
        slot_info_t [SLOT_COUNT-1:0] slots;
        addr_t                       pred;
        if (arst_n && bundle_valid) begin
            predict(exp_pc, cnt, slots, pred);
            compare_addr({cur_name, " bundle_pc"}, exp_pc, bundle_pc);
            compare_count({cur_name, " bundle_count"}, cnt, bundle_count);
            for (int i = 0; i < SLOT_COUNT; i++)
                compare_slot($sformatf("%s slot %0d at %h", cur_name, i, exp_pc),
                             slots[i], bundle_slots[i]);
            compare_addr({cur_name, " pred_pc"}, pred, pred_pc);
            exp_pc = pred;
            bundles_seen++;
        end
    end

    task automatic add_case(input string name, input addr_t pc, input instr_t w0, input instr_t w1,
                            input instr_t w2, input instr_t w3, input addr_t aux_pc,
                            input instr_t aux_w, input int nb);
        case_name.push_back(name);
        case_pc.push_back(pc);
        case_w0.push_back(w0);
        case_w1.push_back(w1);
        case_w2.push_back(w2);
        case_w3.push_back(w3);
        case_aux_pc.push_back(aux_pc);
        case_aux_w.push_back(aux_w);
        case_nb.push_back(nb);
    endtask

    // stop the fetch chain so memory can change underneath
    task automatic quiesce();
        int t;
        @(negedge clk_in);
        hold = 1'b1;
        t = 0;
        while (pend_live) begin
            @(negedge clk_in);
            if (++t > 50) report_failure("timeout waiting for the cache model to go quiet");
        end
        repeat (4) @(negedge clk_in);
        mem.delete();
    endtask

    task automatic start_fetch(input string name, input addr_t pc, input int nb);
        int t;
        exp_pc       = pc;
        cur_name     = name;
        bundles_seen = 0;
        hold         = 1'b0;
        @(posedge clk_in);
        #1;
        if (l1i_req_valid) report_failure({name, ": request strobe active before redirect"});
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(posedge clk_in);
        #1;
        redirect_valid = 1'b0;
        if (!l1i_req_valid) report_failure({name, ": no request one cycle after redirect"});
        compare_addr({name, " req line"}, pc & ~addr_t'(CACHE_LINE_BYTES - 1), l1i_req.line_addr);
        compare_addr({name, " req offset"}, addr_t'(pc[OFF_W-1:0]), addr_t'(l1i_req.offset));
        // the response needs at least a cycle, so the strobe must drop here
        @(posedge clk_in);
        #1;
        if (l1i_req_valid) report_failure({name, ": request strobe longer than one cycle"});
        t = 0;
        while (bundles_seen < nb) begin
            @(negedge clk_in);
            if (++t > 500) report_failure({name, ": timeout waiting for bundles"});
        end
    endtask

    initial begin
        addr_t c0;
        //        name          pc            w0            w1            w2             w3   aux
        add_case("no_branch",  64'h2000, NOP,          NOP,          NOP,           NOP, 0, NOP, 2);
        add_case("line_end",   64'h2038, NOP,          NOP,          NOP,           NOP, 0, NOP, 2);
        add_case("b_slot1",    64'h3000, NOP,          enc_b(64),    NOP,           NOP, 0, NOP, 2);
        add_case("bcond_back", 64'h3110, NOP,          NOP,          enc_bcond(-16), NOP, 0, NOP, 3);
        add_case("bcond_fwd",  64'h3200, enc_bcond(32), NOP,         NOP,           NOP, 0, NOP, 2);
        add_case("ret_empty",  64'h3300, NOP,          RET,          NOP,           NOP, 0, NOP, 2);
        add_case("bl_ret",     64'h4000, NOP,          enc_bl(512),  NOP,           NOP,
                 64'h4204, RET, 3);

        repeat (4) @(posedge clk_in);
        #1;
        arst_n = 1'b1;
        @(negedge clk_in);
        if (l1i_req_valid || bundle_valid) report_failure("strobe active right after reset");

        for (int r = 0; r < case_name.size(); r++) begin
            quiesce();
            mem[case_pc[r]]      = case_w0[r];
            mem[case_pc[r] + 4]  = case_w1[r];
            mem[case_pc[r] + 8]  = case_w2[r];
            mem[case_pc[r] + 12] = case_w3[r];
            if (case_aux_pc[r] != 0) mem[case_aux_pc[r]] = case_aux_w[r];
            start_fetch(case_name[r], case_pc[r], case_nb[r]);
        end

        // RAS_DEPTH+1 nested calls where each return site holds another RET
        quiesce();
        c0 = 64'h1000_0000;
        for (int k = 0; k <= RAS_DEPTH; k++) begin
            mem[c0 + 256 * k]     = enc_bl(256);
            mem[c0 + 256 * k + 4] = RET;
        end
        mem[c0 + 256 * (RAS_DEPTH + 1)] = RET;
        start_fetch("nested_calls", c0, 2 * RAS_DEPTH + 4);

        $display("Everything OK");
        $finish;
    end

    // overall guard against a hung run
    initial begin
        #200000;
        $display("global timeout, simulation did not finish");
        $display("Something failed");
        $fatal(1);
    end

endmodule

// File: sim.f
hdl/bp_pkg.sv
hdl/fetch_ctrl.sv
hdl/predecode_slot.sv
hdl/return_stack.sv
hdl/bundle_select.sv
hdl/branch_pred_top.sv
testbench/branch_pred_properties.sv
testbench/tb_branch_pred.sv

// File: Bender.yml
package:
  name: branch_pred

sources:
  - hdl/bp_pkg.sv
  - hdl/fetch_ctrl.sv
  - hdl/predecode_slot.sv
  - hdl/return_stack.sv
  - hdl/bundle_select.sv
  - hdl/branch_pred_top.sv
  - target: simulation
    files:
      - testbench/branch_pred_properties.sv
      - testbench/tb_branch_pred.sv
